//--- common/muldiv_pkg.sv
// Internal control definitions of the multiply/divide unit.
// Signedness codes for the multiplier and the divider step count.

`default_nettype none

package muldiv_pkg;

    // Bit 0 marks the first operand as signed, bit 1 the second.
    typedef logic [1:0] signed_mode_t;

    localparam signed_mode_t SM_UNSIGNED = 2'b00;
    localparam signed_mode_t SM_FIRST    = 2'b01;
    localparam signed_mode_t SM_BOTH     = 2'b11;

    // One quotient bit is produced per step.
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

endpackage

`default_nettype wire

//--- common/rv_m_pkg.sv
// RISC-V M extension definitions shared by the multiply/divide unit.
// Holds the funct3 encodings and the data widths of the operations.

`default_nettype none

package rv_m_pkg;

    localparam int XLEN       = 32;
    localparam int HALF_XLEN  = XLEN / 2;  // Operand half fed to the 16x16 MAC.
    localparam int MUL_FAST_W = HALF_XLEN + 1;

    // Funct3 field of the OP opcode with funct7 = 0000001.
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } m_op_e;

endpackage

`default_nettype wire

//--- design/muldiv_ctrl.sv
// Multiply/divide controller.
// Decodes funct3, picks the MUL fast path for small operands, routes the
// enable to one engine and returns that engine's hold and result.

`default_nettype none

module muldiv_ctrl (
    input  rv_m_pkg::m_op_e                op_i,
    input  logic [rv_m_pkg::XLEN-1:0]      first_operand_i,
    input  logic [rv_m_pkg::XLEN-1:0]      second_operand_i,
    input  logic                           enable_i,
    input  logic [rv_m_pkg::XLEN-1:0]      mul_result_i,
    input  logic                           mul_hold_i,
    input  logic [rv_m_pkg::XLEN-1:0]      div_result_i,
    input  logic                           div_hold_i,
    output logic                           mul_enable_o,
    output muldiv_pkg::signed_mode_t       signed_mode_o,
    output logic                           mul_low_o,
    output logic                           single_cycle_o,
    output logic                           div_enable_o,
    output logic                           div_signed_o,
    output logic                           div_rem_o,
    output logic                           hold_o,
    output logic [rv_m_pkg::XLEN-1:0]      result_o
);
    import rv_m_pkg::*;
    import muldiv_pkg::*;

    logic is_div;
    logic a_small;
    logic b_small;
    logic fast_mul;

    // An operand is small when its top 17 bits are all copies of one sign.
    assign a_small = (&first_operand_i[XLEN-1:XLEN-MUL_FAST_W])
                  || !(|first_operand_i[XLEN-1:XLEN-MUL_FAST_W]);
    assign b_small = (&second_operand_i[XLEN-1:XLEN-MUL_FAST_W])
                  || !(|second_operand_i[XLEN-1:XLEN-MUL_FAST_W]);

    always_comb begin
        is_div        = 1'b0;
        signed_mode_o = SM_BOTH;  // The low word of MUL does not depend on signedness.
        mul_low_o     = 1'b0;
        div_signed_o  = 1'b0;
        div_rem_o     = 1'b0;
        unique case (op_i)
            OP_MUL:    mul_low_o = 1'b1;
            OP_MULH:   signed_mode_o = SM_BOTH;
            OP_MULHSU: signed_mode_o = SM_FIRST;
            OP_MULHU:  signed_mode_o = SM_UNSIGNED;
            OP_DIV: begin
                is_div       = 1'b1;
                div_signed_o = 1'b1;
            end
            OP_DIVU: begin
                is_div = 1'b1;
            end
            OP_REM: begin
                is_div       = 1'b1;
                div_signed_o = 1'b1;
                div_rem_o    = 1'b1;
            end
            OP_REMU: begin
                is_div    = 1'b1;
                div_rem_o = 1'b1;
            end
        endcase
    end

    // On the fast path the multiplier stays idle and its first-step
    // product already holds the full low word.
    assign fast_mul       = (op_i == OP_MUL) && a_small && b_small;
    assign single_cycle_o = fast_mul;

    assign mul_enable_o = enable_i && !is_div && !fast_mul;
    assign div_enable_o = enable_i && is_div;

    assign hold_o   = is_div ? div_hold_i : mul_hold_i;
    assign result_o = is_div ? div_result_i : mul_result_i;

endmodule

`default_nettype wire

//--- design/muldiv_unit.sv
// Multiply/divide unit of the execute stage.
// Runs the RV32 M-extension operations on a shared controller,
// a sequential multiplier and an iterative divider.

`default_nettype none

module muldiv_unit (
    input  logic                           clk,
    input  logic                           reset_n,
    input  rv_m_pkg::m_op_e                op_i,
    input  logic [rv_m_pkg::XLEN-1:0]      first_operand_i,
    input  logic [rv_m_pkg::XLEN-1:0]      second_operand_i,
    input  logic                           enable_i,
    input  logic                           stall_i,
    output logic                           hold_o,
    output logic [rv_m_pkg::XLEN-1:0]      result_o
);
    import rv_m_pkg::*;
    import muldiv_pkg::*;

    logic            mul_enable;
    signed_mode_t    signed_mode;
    logic            mul_low;
    logic            single_cycle;
    logic            mul_hold;
    logic [XLEN-1:0] mul_result;
    logic            div_enable;
    logic            div_signed;
    logic            div_rem;
    logic            div_hold;
    logic [XLEN-1:0] div_result;

    muldiv_ctrl u_ctrl (
        .op_i             (op_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .enable_i         (enable_i),
        .mul_result_i     (mul_result),
        .mul_hold_i       (mul_hold),
        .div_result_i     (div_result),
        .div_hold_i       (div_hold),
        .mul_enable_o     (mul_enable),
        .signed_mode_o    (signed_mode),
        .mul_low_o        (mul_low),
        .single_cycle_o   (single_cycle),
        .div_enable_o     (div_enable),
        .div_signed_o     (div_signed),
        .div_rem_o        (div_rem),
        .hold_o           (hold_o),
        .result_o         (result_o)
    );

    mul u_mul (
        .clk              (clk),
        .reset_n          (reset_n),
        .stall_i          (stall_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .signed_mode_i    (signed_mode),
        .enable_i         (mul_enable),
        .mul_low_i        (mul_low),
        .single_cycle_i   (single_cycle),
        .hold_o           (mul_hold),
        .result_o         (mul_result)
    );

    div u_div (
        .clk        (clk),
        .reset_n    (reset_n),
        .stall_i    (stall_i),
        .dividend_i (first_operand_i),
        .divisor_i  (second_operand_i),
        .signed_i   (div_signed),
        .rem_i      (div_rem),
        .enable_i   (div_enable),
        .hold_o     (div_hold),
        .result_o   (div_result)
    );

endmodule

`default_nettype wire

//--- div/div.sv
// Iterative restoring divider with a fixed latency of 34 cycles.
// Works on magnitudes and restores the signs at the end, following the
// RISC-V results for a zero divisor and for signed overflow.

`default_nettype none

module div (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           stall_i,
    input  logic [rv_m_pkg::XLEN-1:0]      dividend_i,
    input  logic [rv_m_pkg::XLEN-1:0]      divisor_i,
    input  logic                           signed_i,
    input  logic                           rem_i,
    input  logic                           enable_i,
    output logic                           hold_o,
    output logic [rv_m_pkg::XLEN-1:0]      result_o
);
    import rv_m_pkg::*;
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e state;

    logic [DIV_CNT_W-1:0] step_cnt;
    logic [XLEN-1:0]      quo_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      divisor_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 rem_sel_q;
    logic                 dividend_neg;
    logic                 divisor_neg;
    logic [XLEN-1:0]      dividend_abs;
    logic [XLEN-1:0]      divisor_abs;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        trial;
    logic [XLEN-1:0]      quo_out;
    logic [XLEN-1:0]      rem_out;

    assign dividend_neg = signed_i && dividend_i[XLEN-1];
    assign divisor_neg  = signed_i && divisor_i[XLEN-1];
    assign dividend_abs = dividend_neg ? -dividend_i : dividend_i;
    assign divisor_abs  = divisor_neg ? -divisor_i : divisor_i;

    // Shift in the next dividend bit and try the subtraction.
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, divisor_q};

    assign hold_o = (state == DIV_IDLE) ? enable_i : (state == DIV_RUN);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            unique case (state)
                DIV_IDLE: begin
                    step_cnt <= '0;
                    if (enable_i) begin
                        state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    if (!stall_i) begin
                        state <= DIV_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DIV_IDLE) && enable_i) begin
            quo_q     <= dividend_abs;
            rem_q     <= '0;
            divisor_q <= divisor_abs;
            // A zero divisor leaves the all-ones quotient unsigned.
            neg_quo_q <= (dividend_neg ^ divisor_neg) && (divisor_i != '0);
            neg_rem_q <= dividend_neg;
            rem_sel_q <= rem_i;
        end else if (state == DIV_RUN) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Most negative over minus one needs no special path.
    // The magnitude quotient 2^31 negates back to itself and the remainder is zero.
    assign quo_out  = neg_quo_q ? -quo_q : quo_q;
    assign rem_out  = neg_rem_q ? -rem_q : rem_q;
    assign result_o = rem_sel_q ? rem_out : quo_out;

endmodule

`default_nettype wire

//--- mul/mul.sv
// Sequential multiplier around one 16x16 multiply-accumulate.
// Walks the four half products to form the high word, or stops after three
// for the low word. The first step alone covers small signed operands.

`default_nettype none

module mul (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           stall_i,
    input  logic [rv_m_pkg::XLEN-1:0]      first_operand_i,
    input  logic [rv_m_pkg::XLEN-1:0]      second_operand_i,
    input  muldiv_pkg::signed_mode_t       signed_mode_i,
    input  logic                           enable_i,
    input  logic                           mul_low_i,
    input  logic                           single_cycle_i,
    output logic                           hold_o,
    output logic [rv_m_pkg::XLEN-1:0]      result_o
);
    import rv_m_pkg::*;

    // A 17x17 signed product plus carries from the middle terms.
    localparam int MAC_W = XLEN + 3;

    typedef enum logic [3:0] {
        STEP_LL = 4'b0001,
        STEP_LH = 4'b0010,
        STEP_HL = 4'b0100,
        STEP_HH = 4'b1000
    } step_e;

    step_e state;
    step_e state_next;

    logic [HALF_XLEN-1:0] a_half;
    logic [HALF_XLEN-1:0] b_half;
    logic                 a_sign;
    logic                 b_sign;
    logic [MAC_W-1:0]     accum;
    logic [MAC_W-1:0]     mac_out;
    logic [MAC_W-1:0]     partial;
    logic [MAC_W-1:0]     mac_reg;
    logic                 start;
    logic                 last_step;
    logic                 any_signed;
    logic                 hold_q;

    assign any_signed = |signed_mode_i;
    assign start      = enable_i && (state == STEP_LL);
    assign last_step  = (state == STEP_HH) || ((state == STEP_HL) && mul_low_i);
    assign hold_o     = start || hold_q;
    assign result_o   = partial[XLEN-1:0];

    assign mac_out = $signed({a_sign, a_half}) * $signed({b_sign, b_half}) + $signed(accum);

    always_comb begin
        unique case (state)
            STEP_LH: begin
                a_half = first_operand_i[HALF_XLEN-1:0];
                b_half = second_operand_i[XLEN-1:HALF_XLEN];
                a_sign = 1'b0;
                b_sign = signed_mode_i[1] && second_operand_i[XLEN-1];
            end
            STEP_HL: begin
                a_half = first_operand_i[XLEN-1:HALF_XLEN];
                b_half = second_operand_i[HALF_XLEN-1:0];
                a_sign = signed_mode_i[0] && first_operand_i[XLEN-1];
                b_sign = 1'b0;
            end
            STEP_HH: begin
                a_half = first_operand_i[XLEN-1:HALF_XLEN];
                b_half = second_operand_i[XLEN-1:HALF_XLEN];
                a_sign = signed_mode_i[0] && first_operand_i[XLEN-1];
                b_sign = signed_mode_i[1] && second_operand_i[XLEN-1];
            end
            default: begin
                // Low halves are unsigned, except when they stand for a whole small operand.
                a_half = first_operand_i[HALF_XLEN-1:0];
                b_half = second_operand_i[HALF_XLEN-1:0];
                a_sign = single_cycle_i && signed_mode_i[0] && first_operand_i[XLEN-1];
                b_sign = single_cycle_i && signed_mode_i[1] && second_operand_i[XLEN-1];
            end
        endcase
    end

    always_comb begin
        unique case (state)
            STEP_LH: accum = MAC_W'(mac_reg[XLEN-1:HALF_XLEN]);
            STEP_HL: accum = mul_low_i ? MAC_W'(mac_reg[XLEN-1:HALF_XLEN]) : mac_reg;
            STEP_HH: begin
                // Carry the middle sum down by one half, keeping its sign.
                accum = {{(HALF_XLEN + 1){any_signed && mac_reg[MAC_W-2]}},
                         mac_reg[MAC_W-2:HALF_XLEN]};
            end
            default: accum = '0;
        endcase
    end

    // In low mode the bottom half of the word is final after the first step.
    always_comb begin
        if (mul_low_i && ((state == STEP_LH) || (state == STEP_HL))) begin
            partial = {{(MAC_W - XLEN){1'b0}}, mac_out[HALF_XLEN-1:0],
                       mac_reg[HALF_XLEN-1:0]};
        end else begin
            partial = mac_out;
        end
    end

    always_comb begin
        unique case (state)
            STEP_LL: state_next = start ? STEP_LH : STEP_LL;
            STEP_LH: state_next = STEP_HL;
            STEP_HL: state_next = mul_low_i ? STEP_LL : STEP_HH;
            default: state_next = STEP_LL;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= STEP_LL;
        end else if (!(last_step && stall_i)) begin  // A stalled result step repeats.
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!(last_step && stall_i)) begin
            mac_reg <= partial;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hold_q <= 1'b0;
        end else begin
            unique case (state)
                STEP_LL: hold_q <= start;
                STEP_LH: hold_q <= !mul_low_i;
                default: hold_q <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiply/divide unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=muldiv_tb_sim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module muldiv_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
fi

if grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
    echo "Simulation passed."
    exit 0
else
    echo "Simulation failed."
    exit 1
fi

//--- tb.f
common/rv_m_pkg.sv
common/muldiv_pkg.sv
design/muldiv_ctrl.sv
mul/mul.sv
div/div.sv
design/muldiv_unit.sv
verification/muldiv_tb.sv

//--- verification/muldiv_tb.sv
// Testbench for the multiply/divide unit.
// Applies a table of directed and random rows and compares each result and
// hold length with a reference model of the M-extension rules.

`default_nettype none

module muldiv_tb;
    import rv_m_pkg::*;
    import muldiv_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM   = 24;
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int ROW_CYCLES   = DIV_STEPS + 8;  // Longest operation plus its stalls.
    localparam int TIMEOUT      = (NUM_ROWS * ROW_CYCLES + 50) * CLK_PERIOD;

    logic            clk;
    logic            reset_n;
    m_op_e           op;
    logic [XLEN-1:0] first_operand;
    logic [XLEN-1:0] second_operand;
    logic            enable;
    logic            stall;
    logic            hold;
    logic [XLEN-1:0] result;

    // Stimulus and expected values, one entry per row.
    m_op_e           op_tab    [NUM_ROWS];
    logic [XLEN-1:0] a_tab     [NUM_ROWS];
    logic [XLEN-1:0] b_tab     [NUM_ROWS];
    int              stall_tab [NUM_ROWS];
    logic [XLEN-1:0] exp_tab   [NUM_ROWS];
    int              hold_tab  [NUM_ROWS];
    int              row_count;
    logic [31:0]     rng_state;

    muldiv_unit UUT (
        .clk              (clk),
        .reset_n          (reset_n),
        .op_i             (op),
        .first_operand_i  (first_operand),
        .second_operand_i (second_operand),
        .enable_i         (enable),
        .stall_i          (stall),
        .hold_o           (hold),
        .result_o         (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // A value fits 17 signed bits when its top 17 bits are all the same.
    function automatic logic fits_17_bits(input logic [XLEN-1:0] v);
        return (v[31:15] == 17'h0) || (v[31:15] == 17'h1ffff);
    endfunction

    function automatic logic [XLEN-1:0] model_result(input m_op_e opc,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] a_ext;
        logic [63:0] b_ext;
        logic [63:0] product;
        logic        overflow;
        int          sa;
        int          sb;
        logic [XLEN-1:0] res;
        a_signed = (opc == OP_MUL) || (opc == OP_MULH) || (opc == OP_MULHSU);
        b_signed = (opc == OP_MUL) || (opc == OP_MULH);
        a_ext    = {{32{a_signed && a[31]}}, a};
        b_ext    = {{32{b_signed && b[31]}}, b};
        product  = a_ext * b_ext;  // Low 64 bits of the sign-extended product are exact.
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        sa       = a;
        sb       = b;
        case (opc)
            OP_MUL:                       res = product[31:0];
            OP_MULH, OP_MULHSU, OP_MULHU: res = product[63:32];
            OP_DIV: begin
                if (b == '0)    res = '1;
                else if (overflow) res = a;
                else            res = sa / sb;
            end
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0)    res = a;
                else if (overflow) res = '0;
                else            res = sa % sb;
            end
            OP_REMU: res = (b == '0) ? a : a % b;
            default: res = '0;
        endcase
        return res;
    endfunction

    // Number of cycles with hold high before the result cycle.
    function automatic int expected_hold(input m_op_e opc, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
        if (opc == OP_MUL) begin
            return (fits_17_bits(a) && fits_17_bits(b)) ? 0 : 2;
        end else if ((opc == OP_MULH) || (opc == OP_MULHSU) || (opc == OP_MULHU)) begin
            return 3;
        end
        return DIV_STEPS + 1;
    endfunction

    task automatic add_row(input m_op_e opc, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input int stalls);
        op_tab[row_count]    = opc;
        a_tab[row_count]     = a;
        b_tab[row_count]     = b;
        stall_tab[row_count] = stalls;
        exp_tab[row_count]   = model_result(opc, a, b);
        hold_tab[row_count]  = expected_hold(opc, a, b);
        row_count++;
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  code;
        int          stalls;
        add_row(OP_MUL,    32'h1234_5678, 32'h9abc_def0, 0);
        add_row(OP_DIV,    32'h8000_0000, 32'hffff_ffff, 0);
        add_row(OP_MUL,    32'h0000_7fff, 32'hffff_8000, 2);  // Fast path under stall.
        add_row(OP_REM,    32'h8000_0000, 32'hffff_ffff, 0);
        add_row(OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 0);
        add_row(OP_DIVU,   32'hdead_beef, 32'h0000_0000, 0);
        add_row(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0);
        add_row(OP_REMU,   32'h0000_1234, 32'h0000_0000, 1);
        add_row(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 0);
        add_row(OP_DIV,    32'hffff_fff9, 32'h0000_0000, 0);
        add_row(OP_MULH,   32'h8000_0000, 32'h8000_0000, 1);
        add_row(OP_REM,    32'hffff_fff9, 32'h0000_0000, 0);
        add_row(OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 0);
        add_row(OP_DIV,    32'hffff_fff9, 32'h0000_0002, 2);
        add_row(OP_MUL,    32'h8000_0000, 32'hffff_ffff, 3);
        add_row(OP_REM,    32'hffff_fff9, 32'h0000_0002, 0);
        add_row(OP_MUL,    32'hffff_fffb, 32'h0000_0003, 0);
        add_row(OP_DIVU,   32'hffff_ffff, 32'h0000_0003, 0);
        add_row(OP_MULHU,  32'h8000_0000, 32'h0000_0002, 0);
        add_row(OP_REMU,   32'h0000_0064, 32'h0000_0007, 3);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            a         = rng_state;
            rng_state = xorshift32(rng_state);
            b         = rng_state;
            if (i % 3 == 2) begin
                // Sign-extended halves send MUL down the fast path.
                a = {{16{a[15]}}, a[15:0]};
                b = {{16{b[15]}}, b[15:0]};
            end
            code   = {i[0], i[2:1]};  // Even rows multiply, odd rows divide.
            stalls = (i % 5 == 4) ? 1 : 0;
            add_row(m_op_e'(code), a, b, stalls);
        end
    endtask

    task automatic check_value(input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s: expected %h, got %h", $time, what, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic run_row(input int idx);
        int    holds;
        int    left;
        string tag;
        tag = $sformatf("row %0d (funct3 %0d)", idx, op_tab[idx]);
        @(posedge clk);
        op             <= op_tab[idx];
        first_operand  <= a_tab[idx];
        second_operand <= b_tab[idx];
        enable         <= 1'b1;
        stall          <= (stall_tab[idx] > 0);
        holds = 0;
        @(negedge clk);
        while (hold) begin
            holds++;
            @(negedge clk);
        end
        check_value(32'(hold_tab[idx]), 32'(holds), {tag, " hold cycles"});
        check_value(exp_tab[idx], result, {tag, " result"});
        left = stall_tab[idx];
        while (left > 0) begin
            left--;
            @(posedge clk);
            stall <= (left > 0);
            @(negedge clk);
            check_value(32'h0, 32'(hold), {tag, " hold while stalled"});
            check_value(exp_tab[idx], result, {tag, " result while stalled"});
        end
    endtask

    initial begin
        reset_n        = 1'b0;
        op             = OP_MUL;
        first_operand  = '0;
        second_operand = '0;
        enable         = 1'b0;
        stall          = 1'b0;
        row_count      = 0;
        rng_state      = 32'h2bb2;
        build_table();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value(32'h0, 32'(hold), "hold after reset");
        // Rows follow each other with no idle cycle in between.
        for (int i = 0; i < row_count; i++) begin
            run_row(i);
        end
        @(posedge clk);
        enable <= 1'b0;
        stall  <= 1'b0;
        @(negedge clk);
        check_value(32'h0, 32'(hold), "hold after the last row");
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired: the unit never completed the table of operations.");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Timeout.");
    end

endmodule

`default_nettype wire
